/* source/sifh_params.svh */
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// width of one incoming data word
`define Np 10
// bin address width, upper bits of a timestamp
`define Nb 6
// bin counter width, saturates at all ones
`define peakMax 8

// number of bins in one pixel histogram
`define BIN_NUM (1 << `Nb)

// acquisitions folded into one histogram
`define ACQ_NUM 4
`define ACQ_W $clog2(`ACQ_NUM)

// pixels per frame, index wraps after the last one
`define PIXEL_NUM 4
`define PIX_W $clog2(`PIXEL_NUM)

`endif

/* source/sifhCtrlPkg.sv */
`default_nettype none

package sifhCtrlPkg;

    // execute stage control
    // stAccum  photon read-modify-write
    // stScan   sweep, clear and stream every bin
    // stDrain  wait for the last scan read to return
    typedef enum logic [1:0] {
        stAccum = 2'd0,
        stScan  = 2'd1,
        stDrain = 2'd2
    } histState_e;

    // result stage control
    // pkIdle waits for the first bin of a scan
    typedef enum logic {
        pkIdle  = 1'b0,
        pkTrack = 1'b1
    } peakState_e;

endpackage

`default_nettype wire

/* source/sifhDataPkg.sv */
`default_nettype none

`include "sifh_params.svh"

package sifhDataPkg;

    // class of one decoded data word
    typedef enum logic [1:0] {
        opIdle   = 2'd0,
        opHit    = 2'd1,
        opAcqEnd = 2'd2
    } wordOp_e;

    typedef logic [`Nb-1:0]      bin_t;
    typedef logic [`peakMax-1:0] count_t;

    // counter ceiling, a full bin stays here
    localparam count_t countMax = '1;

endpackage

`default_nettype wire

/* source/timestampDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module timestampDecode (
    input  logic                 clk,
    input  logic                 arstN,
    // one word per cycle from the pixel front end
    input  logic [`Np-1:0]       data,
    // class of the word sampled on the previous edge
    output sifhDataPkg::wordOp_e wordOp,
    // bin of that word, only meaningful for a hit
    output logic [`Nb-1:0]       bin
);

    logic isIdle;
    logic isAcqEnd;

    // zero means no photon arrived this cycle
    assign isIdle = (data == '0);

    // all ones closes one acquisition
    assign isAcqEnd = (data == '1);

    // word class, registered
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wordOp <= sifhDataPkg::opIdle;
        end else begin
            if (isIdle) begin
                wordOp <= sifhDataPkg::opIdle;
            end else if (isAcqEnd) begin
                wordOp <= sifhDataPkg::opAcqEnd;
            end else begin
                // any other value is a timestamp
                wordOp <= sifhDataPkg::opHit;
            end
        end
    end

    // bin index, upper bits of the timestamp
    // coarse time, the lower bits are dropped
    always_ff @(posedge clk) begin
        bin <= data[`Np-1 -: `Nb];
    end

endmodule

`default_nettype wire

/* source/histRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module histRam (
    input  logic                clk,
    // port a, write side
    input  logic                wEnable,
    input  logic                writeFlag,
    input  logic [`Nb-1:0]      waddr,
    input  logic [`peakMax-1:0] newCounts,
    // port b, registered read side
    input  logic                rEnable,
    input  logic                readFlag,
    input  logic [`Nb-1:0]      raddr,
    output logic [`peakMax-1:0] counts
);

    logic [`peakMax-1:0] mem [`BIN_NUM];

    // empty histogram at power up
    initial begin
        for (int i = 0; i < `BIN_NUM; i++) begin
            mem[i] = '0;
        end
    end

    // port a, memory enable and write enable
    always @(posedge clk) begin
        if (wEnable && writeFlag) begin
            mem[waddr] <= newCounts;
        end
    end

    // port b, old data on an address collision
    // forwarding upstream hides this case
    always @(posedge clk) begin
        if (rEnable && readFlag) begin
            counts <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* source/SiFH_FSM.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module SiFH_FSM (
    input  logic                 clk,
    input  logic                 arstN,
    // decoded word
    input  sifhDataPkg::wordOp_e wordOp,
    input  logic [`Nb-1:0]       bin,
    // port b read data, one cycle after rEnable
    input  logic [`peakMax-1:0]  counts,
    output logic [`Nb-1:0]       waddr,
    output logic [`Nb-1:0]       raddr,
    output logic                 wEnable,
    output logic                 rEnable,
    output logic                 writeFlag,
    output logic                 readFlag,
    output logic [`peakMax-1:0]  newCounts,
    output logic                 busy,
    // scan stream to the result stage
    output logic                 scanValid,
    output logic                 scanLast,
    output logic [`Nb-1:0]       scanBin,
    output logic [`peakMax-1:0]  scanCount,
    output logic [`PIX_W-1:0]    scanPixel
);

    localparam logic [`ACQ_W-1:0] acqLast = (`ACQ_W)'(`ACQ_NUM - 1);
    localparam logic [`PIX_W-1:0] pixLast = (`PIX_W)'(`PIXEL_NUM - 1);

    sifhCtrlPkg::histState_e state;
    logic [`ACQ_W-1:0]       acqCnt;
    sifhDataPkg::bin_t       scanAddr;
    logic                    busyReg;
    // busy as seen when the decoded word was sampled
    logic                    busyD;
    logic                    lastAcq;
    // stage 1 is the read request on port b
    logic                    clr1;
    logic                    last1;
    // stage 2 holds the read whose counts are back
    logic                    v2;
    logic                    clr2;
    logic                    last2;
    sifhDataPkg::bin_t       a2;
    logic                    fwd;
    sifhDataPkg::count_t     fwdData;
    sifhDataPkg::count_t     base;
    sifhDataPkg::count_t     inc;

    // final acquisition end of this pixel
    assign lastAcq = (state == sifhCtrlPkg::stAccum) && !busyD &&
                     (wordOp == sifhDataPkg::opAcqEnd) && (acqCnt == acqLast);
    // raised at once so the source idles from the next word on
    assign busy = busyReg | lastAcq;

    // pending write bypasses the stale ram word
    assign base = fwd ? fwdData : counts;
    // saturating increment
    assign inc = (base == sifhDataPkg::countMax) ? base : base + 1'b1;

    // port a, write back two edges after the read request
    assign waddr     = a2;
    assign newCounts = clr2 ? '0 : inc;
    assign writeFlag = v2;
    // a full bin needs no write unless it is being cleared
    assign wEnable   = v2 && (clr2 || (base != sifhDataPkg::countMax));
    // port b busy while a request or its data is in the pipe
    assign readFlag  = rEnable | v2;

    // scan stream
    assign scanValid = v2 & clr2;
    assign scanLast  = scanValid & last2;
    assign scanBin   = a2;
    assign scanCount = base;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= sifhCtrlPkg::stAccum;
            acqCnt    <= '0;
            scanAddr  <= '0;
            scanPixel <= '0;
            busyReg   <= 1'b0;
            busyD     <= 1'b0;
            rEnable   <= 1'b0;
            clr1      <= 1'b0;
            last1     <= 1'b0;
            v2        <= 1'b0;
            clr2      <= 1'b0;
            last2     <= 1'b0;
            fwd       <= 1'b0;
        end else begin
            busyD <= busy;
            v2    <= rEnable;
            clr2  <= clr1;
            last2 <= last1;
            // write and read of one bin on the same edge
            fwd   <= wEnable && rEnable && (waddr == raddr);
            // no request unless a state asks
            rEnable <= 1'b0;
            clr1    <= 1'b0;
            last1   <= 1'b0;
            case (state)
                sifhCtrlPkg::stAccum: begin
                    // words sampled under busy are dropped
                    if (!busyD && (wordOp == sifhDataPkg::opHit)) begin
                        rEnable <= 1'b1;
                    end
                    if (lastAcq) begin
                        acqCnt   <= '0;
                        busyReg  <= 1'b1;
                        scanAddr <= '0;
                        state    <= sifhCtrlPkg::stScan;
                    end else if (!busyD && (wordOp == sifhDataPkg::opAcqEnd)) begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end
                sifhCtrlPkg::stScan: begin
                    // one bin per cycle, zero written behind it
                    rEnable  <= 1'b1;
                    clr1     <= 1'b1;
                    last1    <= (scanAddr == '1);
                    scanAddr <= scanAddr + 1'b1;
                    if (scanAddr == '1) begin
                        state <= sifhCtrlPkg::stDrain;
                    end
                end
                sifhCtrlPkg::stDrain: begin
                    // last bin is out, next pixel
                    if (scanLast) begin
                        busyReg   <= 1'b0;
                        state     <= sifhCtrlPkg::stAccum;
                        scanPixel <= (scanPixel == pixLast) ? '0 : scanPixel + 1'b1;
                    end
                end
                default: begin
                    state <= sifhCtrlPkg::stAccum;
                end
            endcase
        end
    end

    // addresses and forwarded data
    always_ff @(posedge clk) begin
        raddr   <= (state == sifhCtrlPkg::stScan) ? scanAddr : bin;
        a2      <= raddr;
        fwdData <= newCounts;
    end

endmodule

`default_nettype wire

/* source/peakFinder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module peakFinder (
    input  logic                clk,
    input  logic                arstN,
    // scan stream from the execute stage
    input  logic                scanValid,
    input  logic                scanLast,
    input  logic [`Nb-1:0]      scanBin,
    input  logic [`peakMax-1:0] scanCount,
    input  logic [`PIX_W-1:0]   scanPixel,
    // result, held until the next pulse
    output logic                peakValid,
    output logic [`Nb-1:0]      peakBin,
    output logic [`peakMax-1:0] peakCount,
    output logic [`PIX_W-1:0]   pixelIndex
);

    sifhCtrlPkg::peakState_e state;
    sifhDataPkg::bin_t       maxBin;
    sifhDataPkg::count_t     maxCount;
    logic                    takeNew;
    sifhDataPkg::bin_t       candBin;
    sifhDataPkg::count_t     candCount;

    // first bin always taken, later only strictly greater
    // so on a tie the lower bin stays
    assign takeNew   = (state == sifhCtrlPkg::pkIdle) || (scanCount > maxCount);
    assign candBin   = takeNew ? scanBin : maxBin;
    assign candCount = takeNew ? scanCount : maxCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= sifhCtrlPkg::pkIdle;
            peakValid  <= 1'b0;
            peakBin    <= '0;
            peakCount  <= '0;
            pixelIndex <= '0;
        end else begin
            peakValid <= 1'b0;
            if (scanValid) begin
                if (scanLast) begin
                    // includes the last bin itself
                    peakValid  <= 1'b1;
                    peakBin    <= candBin;
                    peakCount  <= candCount;
                    pixelIndex <= scanPixel;
                    state      <= sifhCtrlPkg::pkIdle;
                end else begin
                    state <= sifhCtrlPkg::pkTrack;
                end
            end
        end
    end

    // running maximum over the scan
    always_ff @(posedge clk) begin
        if (scanValid) begin
            maxBin   <= candBin;
            maxCount <= candCount;
        end
    end

endmodule

`default_nettype wire

/* source/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module sifhTop (
    input  logic                clk,
    input  logic                arstN,
    input  logic [`Np-1:0]      data,
    // source sends idle words while high
    output logic                busy,
    output logic                peakValid,
    output logic [`Nb-1:0]      peakBin,
    output logic [`peakMax-1:0] peakCount,
    output logic [`PIX_W-1:0]   pixelIndex
);

    sifhDataPkg::wordOp_e wordOp;
    logic [`Nb-1:0]       bin;
    // ram ports
    logic [`peakMax-1:0]  counts;
    logic [`peakMax-1:0]  newCounts;
    logic [`Nb-1:0]       waddr;
    logic [`Nb-1:0]       raddr;
    logic                 wEnable;
    logic                 rEnable;
    logic                 writeFlag;
    logic                 readFlag;
    // scan stream
    logic                 scanValid;
    logic                 scanLast;
    logic [`Nb-1:0]       scanBin;
    logic [`peakMax-1:0]  scanCount;
    logic [`PIX_W-1:0]    scanPixel;

    // decode
    timestampDecode uDecode (
        .clk    (clk),
        .arstN  (arstN),
        .data   (data),
        .wordOp (wordOp),
        .bin    (bin)
    );

    // execute, owns both ram ports
    SiFH_FSM SiFH_FSM (
        .clk       (clk),
        .arstN     (arstN),
        .wordOp    (wordOp),
        .bin       (bin),
        .counts    (counts),
        .waddr     (waddr),
        .raddr     (raddr),
        .wEnable   (wEnable),
        .rEnable   (rEnable),
        .writeFlag (writeFlag),
        .readFlag  (readFlag),
        .newCounts (newCounts),
        .busy      (busy),
        .scanValid (scanValid),
        .scanLast  (scanLast),
        .scanBin   (scanBin),
        .scanCount (scanCount),
        .scanPixel (scanPixel)
    );

    histRam uRam (
        .clk       (clk),
        .wEnable   (wEnable),
        .writeFlag (writeFlag),
        .waddr     (waddr),
        .newCounts (newCounts),
        .rEnable   (rEnable),
        .readFlag  (readFlag),
        .raddr     (raddr),
        .counts    (counts)
    );

    // result
    peakFinder uPeak (
        .clk        (clk),
        .arstN      (arstN),
        .scanValid  (scanValid),
        .scanLast   (scanLast),
        .scanBin    (scanBin),
        .scanCount  (scanCount),
        .scanPixel  (scanPixel),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .pixelIndex (pixelIndex)
    );

endmodule

`default_nettype wire

/* sim/sifh_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhChk (
    input logic                 clk,
    input logic                 arstN,
    input sifhDataPkg::wordOp_e wordOp,
    input logic                 busy,
    input logic                 wEnable,
    input logic                 rEnable,
    input logic                 writeFlag,
    input logic                 readFlag,
    input logic                 scanValid
);

    // outside a scan a write follows a decoded hit two edges back
    assert property (@(posedge clk) disable iff (!arstN)
        ($rose(wEnable) && !busy) |-> $past(wordOp == sifhDataPkg::opHit, 2))
    else $error("write on port a with no decoded hit behind it");

    // both ram ports and their activity strobes quiet in reset
    assert property (@(posedge clk) !arstN |->
        (!rEnable && !wEnable && !writeFlag && !readFlag))
    else $error("ram port or activity strobe high during reset");

    // scan stream only inside the busy window
    assert property (@(posedge clk) disable iff (!arstN) scanValid |-> busy)
    else $error("scan data while busy is low");

endmodule

bind SiFH_FSM sifhChk uChk (
    .clk       (clk),
    .arstN     (arstN),
    .wordOp    (wordOp),
    .busy      (busy),
    .wEnable   (wEnable),
    .rEnable   (rEnable),
    .writeFlag (writeFlag),
    .readFlag  (readFlag),
    .scanValid (scanValid)
);

`default_nettype wire

/* sim/sifhMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module sifhMonitor (
    input logic                clk,
    input logic                arstN,
    input logic [`Np-1:0]      data,
    input logic                busy,
    input logic                peakValid,
    input logic [`Nb-1:0]      peakBin,
    input logic [`peakMax-1:0] peakCount,
    input logic [`PIX_W-1:0]   pixelIndex
);

    int errors = 0;
    int checks = 0;

    // model histogram survives reset as the ram does
    logic [`peakMax-1:0] hist [`BIN_NUM];
    int                  acqCnt = 0;
    int                  pixel = 0;
    logic                expectBusy = 1'b0;
    // results owed by the DUT in order of completion
    int                  expBin [$];
    int                  expCount [$];
    int                  expPix [$];

    initial begin
        for (int i = 0; i < `BIN_NUM; i++) begin
            hist[i] = '0;
        end
    end

    function automatic int pendingResults();
        return expBin.size();
    endfunction

    // lowest bin wins a tie and the model clears for the next pixel
    task automatic closePixel();
        int best;
        int bestBin;
        best = hist[0];
        bestBin = 0;
        for (int b = 1; b < `BIN_NUM; b++) begin
            if (hist[b] > best) begin
                best = hist[b];
                bestBin = b;
            end
        end
        expBin.push_back(bestBin);
        expCount.push_back(best);
        expPix.push_back(pixel);
        for (int b = 0; b < `BIN_NUM; b++) begin
            hist[b] = '0;
        end
        pixel = (pixel + 1) % `PIXEL_NUM;
        acqCnt = 0;
        expectBusy = 1'b1;
    endtask

    // sample on the falling edge where inputs and outputs have settled
    always @(negedge clk) begin
        if (!arstN) begin
            acqCnt = 0;
            pixel = 0;
            expectBusy = 1'b0;
            expBin.delete();
            expCount.delete();
            expPix.delete();
            checks++;
            if (busy || peakValid) begin
                errors++;
                $display("[ERROR] %0t: busy or peakValid high during reset", $time);
            end
        end else begin
            if (peakValid) begin
                checks++;
                if (expBin.size() == 0) begin
                    errors++;
                    $display("[ERROR] %0t: peakValid with no finished pixel", $time);
                end else begin
                    if (peakBin != expBin[0] || peakCount != expCount[0] ||
                        pixelIndex != expPix[0]) begin
                        errors++;
                        $display("[ERROR] %0t: pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                                 $time, pixelIndex, peakBin, peakCount,
                                 expPix[0], expBin[0], expCount[0]);
                    end
                    void'(expBin.pop_front());
                    void'(expCount.pop_front());
                    void'(expPix.pop_front());
                end
                expectBusy = 1'b0;
            end
            // high from the closing acquisition end until the peak pulse
            if (busy != expectBusy) begin
                errors++;
                $display("[ERROR] %0t: busy is %0b, expected %0b", $time, busy, expectBusy);
            end
            // words seen under busy are dropped
            if (!busy && data != '0) begin
                if (data == '1) begin
                    acqCnt++;
                    if (acqCnt == `ACQ_NUM) begin
                        closePixel();
                    end
                end else if (hist[data[`Np-1 -: `Nb]] != '1) begin
                    hist[data[`Np-1 -: `Nb]] = hist[data[`Np-1 -: `Nb]] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_params.svh"

module sifhClock #(
    parameter time PERIOD = 40ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

module sifhTb;

    localparam time clkPeriod = 40ns;
    // rough word budget of all tests, and pixels scanned
    localparam int stimWords = 1000;
    localparam int pixelCount = 8;

    logic                clk;
    logic                arstN;
    logic [`Np-1:0]      data;
    logic                busy;
    logic                peakValid;
    logic [`Nb-1:0]      peakBin;
    logic [`peakMax-1:0] peakCount;
    logic [`PIX_W-1:0]   pixelIndex;
    logic [31:0]         lfsrState = 32'h51f3;
    int                  testNum = 0;
    int                  errMark = 0;

    sifhClock #(.PERIOD(clkPeriod)) uClock (.clk(clk));

    sifhTop UUT (
        .clk        (clk),
        .arstN      (arstN),
        .data       (data),
        .busy       (busy),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .pixelIndex (pixelIndex)
    );

    sifhMonitor mon (
        .clk        (clk),
        .arstN      (arstN),
        .data       (data),
        .busy       (busy),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .pixelIndex (pixelIndex)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    // holds off while busy, idle words in the gap
    task automatic sendWord(input logic [`Np-1:0] w);
        @(posedge clk);
        #2;
        while (busy) begin
            data = '0;
            @(posedge clk);
            #2;
        end
        data = w;
    endtask

    task automatic randomAcq(input int words);
        logic [31:0] r;
        for (int i = 0; i < words; i++) begin
            r = randBits(2);
            if (r[1:0] == 2'd0) begin
                sendWord('0);
            end else begin
                r = randBits(`Np);
                // keep clear of the idle and end codes
                if (r[`Np-1:0] == '0 || r[`Np-1:0] == '1) begin
                    r = 32'h155;
                end
                sendWord(r[`Np-1:0]);
            end
        end
        sendWord('1);
    endtask

    task automatic hitBurst(input logic [`Nb-1:0] b, input int n);
        for (int i = 0; i < n; i++) begin
            sendWord({b, 4'h3});
        end
    endtask

    task automatic waitPeak();
        int n;
        n = 0;
        sendWord('0);
        while (!peakValid && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!peakValid) begin
            mon.errors++;
            $display("no peak result within 200 cycles at %0t", $time);
        end
        @(posedge clk);
    endtask

    task automatic endTest(input string name);
        int e;
        e = mon.errors - errMark;
        testNum++;
        $display("test %0d %s: %s (%0d errors)", testNum, name, (e == 0) ? "ok" : "FAILED", e);
        errMark = mon.errors;
    endtask

    // watchdog
    initial begin
        #((stimWords + 80 * pixelCount) * clkPeriod);
        $display("watchdog expired, the run did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] r;
        data = '0;
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arstN = 1'b1;

        for (int a = 0; a < `ACQ_NUM; a++) begin
            randomAcq(40);
        end
        waitPeak();
        endTest("random hits");

        // consecutive hits, forwarding path
        for (int a = 0; a < `ACQ_NUM; a++) begin
            hitBurst(6'd5, 6);
            hitBurst(6'd6, 3);
            hitBurst(6'd5, 3);
            sendWord('1);
        end
        waitPeak();
        endTest("back to back hits");

        for (int a = 0; a < `ACQ_NUM; a++) begin
            hitBurst(6'd9, 75);
            sendWord('1);
        end
        waitPeak();
        endTest("saturation");

        for (int a = 0; a < `ACQ_NUM; a++) begin
            sendWord('1);
        end
        waitPeak();
        endTest("empty pixel");

        // junk under busy, then one more pixel, index wraps
        for (int a = 0; a < `ACQ_NUM; a++) begin
            randomAcq(20);
        end
        @(posedge clk);
        #2;
        while (busy) begin
            r = randBits(`Np);
            data = (r[2:0] == 3'd0) ? '1 : (r[`Np-1:0] | 10'h010);
            @(posedge clk);
            #2;
        end
        data = '0;
        @(negedge clk);
        for (int a = 0; a < `ACQ_NUM; a++) begin
            randomAcq(20);
        end
        waitPeak();
        endTest("words under busy");

        // reset with a pixel half done
        randomAcq(20);
        hitBurst(6'd20, 5);
        repeat (5) sendWord('0);
        @(posedge clk);
        #2;
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arstN = 1'b1;
        repeat (10) sendWord('0);
        for (int a = 0; a < `ACQ_NUM; a++) begin
            randomAcq(20);
        end
        waitPeak();
        endTest("reset mid run");

        repeat (3) @(posedge clk);
        if (mon.pendingResults() != 0) begin
            mon.errors++;
            $display("a finished pixel never reported its peak");
        end
        $display("tests %0d, checks %0d, errors %0d", testNum, mon.checks, mon.errors);
        if (mon.errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/sifhCtrlPkg.sv
source/sifhDataPkg.sv
source/timestampDecode.sv
source/histRam.sv
source/SiFH_FSM.sv
source/peakFinder.sv
source/sifhTop.sv
sim/sifh_chk.sv
sim/sifhMonitor.sv
sim/sifhTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the histogram core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module sifhTb -o sifhSim \
    || { echo "build failed"; exit 1; }

simOut="$(./obj_dir/sifhSim)"
echo "$simOut"

echo "$simOut" | grep -qx "Finished with no errors" && exit 0 || exit 1
